// ==== src.f ====
+incdir+src
src/refwin_pkg.sv
src/bank_if.sv
src/refwin_regs.sv
src/refwin_bank.sv
src/refwin_bank_ctrl.sv
src/refwin_pel_select.sv
src/refwin_top.sv
verification/refwin_clkgen.sv
verification/refwin_tb.sv

// ==== src/bank_if.sv ====
// ****************************************
// Bank access bundle
// Write port and registered read port
// ****************************************

interface bank_if;

    logic                  wen;
    refwin_pkg::row_addr_t waddr;
    refwin_pkg::bank_row_t wdata;
    logic                  rden;
    refwin_pkg::row_addr_t raddr;
    refwin_pkg::bank_row_t rdata;

    modport ctrl (
        output wen, waddr, wdata, rden, raddr,
        input  rdata
    );

    modport bank (
        input  wen, waddr, wdata, rden, raddr,
        output rdata
    );

endinterface

// ==== src/refwin_bank.sv ====
// ****************************************
// Reference row bank
// Synchronous write, registered read
// ****************************************

`include "refwin_consts.svh"

module refwin_bank (
    input  logic clk,
    input  logic rstn,
    bank_if.bank port
);

    refwin_pkg::bank_row_t mem [`REFWIN_BANK_DEPTH];

    always_ff @(posedge clk) begin
        if (port.wen) begin
            mem[port.waddr] <= port.wdata;
        end
    end

    // Read register holds between reads
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            port.rdata <= '0;
        end else if (port.rden) begin
            port.rdata <= mem[port.raddr];
        end
    end

endmodule

// ==== src/refwin_bank_ctrl.sv ====
// ****************************************
// Bank rotation and routing
// Load bank select, row clamp, window build
// ****************************************

`include "refwin_consts.svh"

module refwin_bank_ctrl (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   start_i,
    input  logic                   load_valid_i,
    input  refwin_pkg::row_addr_t  load_addr_i,
    input  refwin_pkg::bank_row_t  load_data_i,
    input  logic                   fetch_en_i,
    input  refwin_pkg::row_addr_t  fetch_y_i,
    input  logic [4:0]             pic_rows_i,
    bank_if.ctrl                   bank0_o,
    bank_if.ctrl                   bank1_o,
    bank_if.ctrl                   bank2_o,
    bank_if.ctrl                   bank3_o,
    output refwin_pkg::window_t    window_o,
    output logic                   rd_valid_o
);

    refwin_pkg::rot_t       rot;
    refwin_pkg::rot_t       rot_q;       // Rotation at request time
    refwin_pkg::rot_t       load_bank;
    refwin_pkg::rot_t       win_l;
    refwin_pkg::rot_t       win_m;
    refwin_pkg::row_addr_t  rd_row;
    logic [`REFWIN_BANK_NUM-1:0] load_oh;
    refwin_pkg::bank_row_t  rdata_a [`REFWIN_BANK_NUM];

    // ****************************************
    // Rotation
    // ****************************************
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rot <= '0;
        end else if (start_i) begin
            rot <= rot + 2'd1;   // Wraps 3 -> 0
        end
    end

    assign load_bank = rot + 2'd1;
    assign load_oh   = 4'b0001 << load_bank;

    // Clamp to last picture row
    assign rd_row = ({1'b0, fetch_y_i} < pic_rows_i) ? fetch_y_i
                                                     : refwin_pkg::row_addr_t'(pic_rows_i - 5'd1);

    // ****************************************
    // Bank routing
    // ****************************************
    assign bank0_o.wen   = load_valid_i & load_oh[0];
    assign bank0_o.waddr = load_addr_i;
    assign bank0_o.wdata = load_data_i;
    assign bank0_o.rden  = fetch_en_i & ~load_oh[0];
    assign bank0_o.raddr = rd_row;

    assign bank1_o.wen   = load_valid_i & load_oh[1];
    assign bank1_o.waddr = load_addr_i;
    assign bank1_o.wdata = load_data_i;
    assign bank1_o.rden  = fetch_en_i & ~load_oh[1];
    assign bank1_o.raddr = rd_row;

    assign bank2_o.wen   = load_valid_i & load_oh[2];
    assign bank2_o.waddr = load_addr_i;
    assign bank2_o.wdata = load_data_i;
    assign bank2_o.rden  = fetch_en_i & ~load_oh[2];
    assign bank2_o.raddr = rd_row;

    assign bank3_o.wen   = load_valid_i & load_oh[3];
    assign bank3_o.waddr = load_addr_i;
    assign bank3_o.wdata = load_data_i;
    assign bank3_o.rden  = fetch_en_i & ~load_oh[3];
    assign bank3_o.raddr = rd_row;

    assign rdata_a[0] = bank0_o.rdata;
    assign rdata_a[1] = bank1_o.rdata;
    assign rdata_a[2] = bank2_o.rdata;
    assign rdata_a[3] = bank3_o.rdata;

    // ****************************************
    // Window assembly
    // ****************************************
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rot_q      <= '0;
            rd_valid_o <= 1'b0;
        end else begin
            rd_valid_o <= fetch_en_i;
            if (fetch_en_i) begin
                rot_q <= rot;
            end
        end
    end

    assign win_l = rot_q + 2'd2;
    assign win_m = rot_q + 2'd3;

    // Left to right: r+2, r+3, r
    assign window_o = {rdata_a[win_l], rdata_a[win_m], rdata_a[rot_q]};

endmodule

// ==== src/refwin_consts.svh ====
// ****************************************
// Reference window constants
// Pixel, bank and fetch sizes
// ****************************************

`ifndef REFWIN_CONSTS_SVH
`define REFWIN_CONSTS_SVH

// Pixel and bank geometry
`define REFWIN_PIXEL_WIDTH 8   // Bits per luma pixel
`define REFWIN_BANK_PELS   8   // Pixels in one bank row
`define REFWIN_BANK_DEPTH  16  // Rows per bank
`define REFWIN_BANK_NUM    4

// Fetch result
`define REFWIN_OUT_PELS    4

// Address widths
`define REFWIN_ROW_AW      4   // Row index
`define REFWIN_X_W         5   // Horizontal offset into window

`endif

// ==== src/refwin_pel_select.sv ====
// ****************************************
// Pixel selector
// Picks four window pixels by offset and mode
// ****************************************

`include "refwin_consts.svh"

module refwin_pel_select (
    input  logic                     clk,
    input  logic                     rstn,
    input  refwin_pkg::window_t      window_i,
    input  logic                     rd_valid_i,
    input  refwin_pkg::pel_ofs_t     x_i,
    input  refwin_pkg::fetch_mode_e  mode_i,
    output refwin_pkg::out_row_t     pel_o,
    output logic                     pel_valid_o
);

    localparam int WIN_PELS = 3 * `REFWIN_BANK_PELS;

    refwin_pkg::pel_t     win_pel [WIN_PELS];
    refwin_pkg::pel_ofs_t x_clamp;
    refwin_pkg::pel_ofs_t step;
    refwin_pkg::out_row_t sel_row;

    // Window pixel 0 is the leftmost
    always_comb begin
        for (int k = 0; k < WIN_PELS; k++) begin
            win_pel[k] = window_i[(WIN_PELS-1-k)*`REFWIN_PIXEL_WIDTH +: `REFWIN_PIXEL_WIDTH];
        end
    end

    assign x_clamp = (x_i > 5'(2*`REFWIN_BANK_PELS)) ? 5'(2*`REFWIN_BANK_PELS) : x_i;
    assign step    = (mode_i == refwin_pkg::MODE_DOWNSAMPLE) ? 5'd2 : 5'd1;

    always_comb begin
        refwin_pkg::pel_ofs_t idx;
        for (int j = 0; j < `REFWIN_OUT_PELS; j++) begin
            idx = x_clamp + refwin_pkg::pel_ofs_t'(j) * step;
            sel_row[(`REFWIN_OUT_PELS-1-j)*`REFWIN_PIXEL_WIDTH +: `REFWIN_PIXEL_WIDTH] = win_pel[idx];
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pel_o       <= '0;
            pel_valid_o <= 1'b0;
        end else begin
            pel_valid_o <= rd_valid_i;
            if (rd_valid_i) begin
                pel_o <= sel_row;
            end
        end
    end

endmodule

// ==== src/refwin_pkg.sv ====
// ****************************************
// Reference window types
// ****************************************

`include "refwin_consts.svh"

package refwin_pkg;

    typedef logic [`REFWIN_PIXEL_WIDTH-1:0] pel_t;

    // Pixel 0 sits in the top byte
    typedef logic [`REFWIN_BANK_PELS*`REFWIN_PIXEL_WIDTH-1:0] bank_row_t;

    // Three bank rows, leftmost bank first
    typedef logic [3*`REFWIN_BANK_PELS*`REFWIN_PIXEL_WIDTH-1:0] window_t;

    typedef logic [`REFWIN_OUT_PELS*`REFWIN_PIXEL_WIDTH-1:0] out_row_t;
    typedef logic [`REFWIN_ROW_AW-1:0] row_addr_t;
    typedef logic [`REFWIN_X_W-1:0] pel_ofs_t;
    typedef logic [1:0] rot_t;

    typedef enum logic {
        MODE_NORMAL     = 1'b0,
        MODE_DOWNSAMPLE = 1'b1   // Every second pixel
    } fetch_mode_e;

    typedef enum logic {
        REG_PIC_ROWS = 1'b0,
        REG_MODE     = 1'b1
    } reg_addr_e;

    typedef logic [7:0] reg_data_t;

endpackage

// ==== src/refwin_regs.sv ====
// ****************************************
// Register block on Wishbone classic
// Picture height and fetch mode
// ****************************************

`include "refwin_consts.svh"

module refwin_regs (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     wb_cyc_i,
    input  logic                     wb_stb_i,
    input  logic                     wb_we_i,
    input  refwin_pkg::reg_addr_e    wb_adr_i,
    input  refwin_pkg::reg_data_t    wb_dat_i,
    output refwin_pkg::reg_data_t    wb_dat_o,
    output logic                     wb_ack_o,
    output logic [4:0]               pic_rows_o,
    output refwin_pkg::fetch_mode_e  mode_o
);

    logic access;

    // New request, not yet acknowledged
    assign access = wb_cyc_i & wb_stb_i & ~wb_ack_o;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wb_ack_o <= 1'b0;
        end else begin
            wb_ack_o <= access;   // One cycle only
        end
    end

    // ****************************************
    // Register writes
    // ****************************************
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pic_rows_o <= 5'(`REFWIN_BANK_DEPTH);
            mode_o     <= refwin_pkg::MODE_NORMAL;
        end else if (access && wb_we_i) begin
            case (wb_adr_i)
                refwin_pkg::REG_PIC_ROWS: begin
                    if (wb_dat_i == '0) begin
                        pic_rows_o <= 5'd1;
                    end else if (wb_dat_i > 8'(`REFWIN_BANK_DEPTH)) begin
                        pic_rows_o <= 5'(`REFWIN_BANK_DEPTH);
                    end else begin
                        pic_rows_o <= wb_dat_i[4:0];
                    end
                end
                refwin_pkg::REG_MODE: mode_o <= refwin_pkg::fetch_mode_e'(wb_dat_i[0]);
                default: ;
            endcase
        end
    end

    // Read data lines up with the ack
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wb_dat_o <= '0;
        end else if (access && !wb_we_i) begin
            if (wb_adr_i == refwin_pkg::REG_MODE) begin
                wb_dat_o <= {7'd0, mode_o};
            end else begin
                wb_dat_o <= {3'd0, pic_rows_o};
            end
        end
    end

endmodule

// ==== src/refwin_top.sv ====
// ****************************************
// Reference window buffer top
// ****************************************

module refwin_top (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   wb_cyc_i,
    input  logic                   wb_stb_i,
    input  logic                   wb_we_i,
    input  refwin_pkg::reg_addr_e  wb_adr_i,
    input  refwin_pkg::reg_data_t  wb_dat_i,
    output refwin_pkg::reg_data_t  wb_dat_o,
    output logic                   wb_ack_o,
    input  logic                   load_valid_i,
    input  refwin_pkg::row_addr_t  load_addr_i,
    input  refwin_pkg::bank_row_t  load_data_i,
    input  logic                   start_i,
    input  logic                   fetch_en_i,
    input  refwin_pkg::pel_ofs_t   fetch_x_i,
    input  refwin_pkg::row_addr_t  fetch_y_i,
    output refwin_pkg::out_row_t   pel_o,
    output logic                   pel_valid_o
);

    logic [4:0]              pic_rows;
    refwin_pkg::fetch_mode_e mode;
    refwin_pkg::fetch_mode_e mode_q;
    refwin_pkg::pel_ofs_t    fetch_x_q;
    refwin_pkg::window_t     window;
    logic                    rd_valid;

    bank_if bank0 ();
    bank_if bank1 ();
    bank_if bank2 ();
    bank_if bank3 ();

    // Offset and mode follow the bank read by one cycle
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            fetch_x_q <= '0;
            mode_q    <= refwin_pkg::MODE_NORMAL;
        end else begin
            fetch_x_q <= fetch_x_i;
            mode_q    <= mode;
        end
    end

    refwin_regs refwin_regs_inst (
        .clk        (clk),
        .rstn       (rstn),
        .wb_cyc_i   (wb_cyc_i),
        .wb_stb_i   (wb_stb_i),
        .wb_we_i    (wb_we_i),
        .wb_adr_i   (wb_adr_i),
        .wb_dat_i   (wb_dat_i),
        .wb_dat_o   (wb_dat_o),
        .wb_ack_o   (wb_ack_o),
        .pic_rows_o (pic_rows),
        .mode_o     (mode)
    );

    refwin_bank_ctrl refwin_bank_ctrl_inst (
        .clk          (clk),
        .rstn         (rstn),
        .start_i      (start_i),
        .load_valid_i (load_valid_i),
        .load_addr_i  (load_addr_i),
        .load_data_i  (load_data_i),
        .fetch_en_i   (fetch_en_i),
        .fetch_y_i    (fetch_y_i),
        .pic_rows_i   (pic_rows),
        .bank0_o      (bank0.ctrl),
        .bank1_o      (bank1.ctrl),
        .bank2_o      (bank2.ctrl),
        .bank3_o      (bank3.ctrl),
        .window_o     (window),
        .rd_valid_o   (rd_valid)
    );

    // ****************************************
    // Banks
    // ****************************************
    refwin_bank refwin_bank0_inst (.clk(clk), .rstn(rstn), .port(bank0.bank));
    refwin_bank refwin_bank1_inst (.clk(clk), .rstn(rstn), .port(bank1.bank));
    refwin_bank refwin_bank2_inst (.clk(clk), .rstn(rstn), .port(bank2.bank));
    refwin_bank refwin_bank3_inst (.clk(clk), .rstn(rstn), .port(bank3.bank));

    refwin_pel_select refwin_pel_select_inst (
        .clk         (clk),
        .rstn        (rstn),
        .window_i    (window),
        .rd_valid_i  (rd_valid),
        .x_i         (fetch_x_q),
        .mode_i      (mode_q),
        .pel_o       (pel_o),
        .pel_valid_o (pel_valid_o)
    );

endmodule

// ==== verification/refwin_clkgen.sv ====
// ****************************************
// Testbench clock source, period 40
// ****************************************

module refwin_clkgen (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
    end

    always #20 clk_o = ~clk_o;

endmodule

// ==== verification/refwin_tb.sv ====
// ****************************************
// Reference window buffer testbench
// Mirror model, random fetches, register access
// ****************************************

`include "refwin_consts.svh"

module refwin_tb;

    localparam int PW          = `REFWIN_PIXEL_WIDTH;
    localparam int DEPTH       = `REFWIN_BANK_DEPTH;
    localparam int NUM_FETCH   = 64;
    localparam int FILL_CYCLES = 4 * (DEPTH + 1) + 8;
    localparam int PLANNED_CYCLES = 16 + 20 * 4 + 3 * FILL_CYCLES + 4 * (NUM_FETCH + 4)
                                  + 2 * (3 * DEPTH + 4);
    localparam int TIMEOUT_CYCLES = 2 * PLANNED_CYCLES;

    logic                    clk;
    logic                    rstn;
    logic                    wb_cyc_i;
    logic                    wb_stb_i;
    logic                    wb_we_i;
    refwin_pkg::reg_addr_e   wb_adr_i;
    refwin_pkg::reg_data_t   wb_dat_i;
    refwin_pkg::reg_data_t   wb_dat_o;
    logic                    wb_ack_o;
    logic                    load_valid_i;
    refwin_pkg::row_addr_t   load_addr_i;
    refwin_pkg::bank_row_t   load_data_i;
    logic                    start_i;
    logic                    fetch_en_i;
    refwin_pkg::pel_ofs_t    fetch_x_i;
    refwin_pkg::row_addr_t   fetch_y_i;
    refwin_pkg::out_row_t    pel_o;
    logic                    pel_valid_o;

    // Mirror of the DUT state
    refwin_pkg::bank_row_t   mem_m [4][DEPTH];
    int                      rot_m      = 0;
    int                      pic_rows_m = DEPTH;
    refwin_pkg::fetch_mode_e mode_m     = refwin_pkg::MODE_NORMAL;

    refwin_pkg::out_row_t    exp_pel_q [$];
    int                      exp_due_q [$];
    int                      cycle = 0;
    logic [15:0]             lfsr  = 16'd32474;

    refwin_clkgen refwin_clkgen_inst (.clk_o(clk));

    refwin_top refwin_top_inst (
        .clk(clk), .rstn(rstn),
        .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_we_i(wb_we_i),
        .wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i), .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o),
        .load_valid_i(load_valid_i), .load_addr_i(load_addr_i), .load_data_i(load_data_i),
        .start_i(start_i),
        .fetch_en_i(fetch_en_i), .fetch_x_i(fetch_x_i), .fetch_y_i(fetch_y_i),
        .pel_o(pel_o), .pel_valid_o(pel_valid_o)
    );

    // ****************************************
    // Helpers and reference model
    // ****************************************
    task automatic stop_with_error(input string what);
        $display("%s", what);
        $display("Simulation finished: FAIL");
        $fatal(1, "Stopped on first error");
    endtask

    task automatic check_pel(input string name, input refwin_pkg::out_row_t got,
                             input refwin_pkg::out_row_t exp);
        if (got !== exp) begin
            stop_with_error($sformatf("ERR %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_reg(input string name, input refwin_pkg::reg_data_t got,
                             input refwin_pkg::reg_data_t exp);
        if (got !== exp) begin
            stop_with_error($sformatf("ERR %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    // Galois LFSR, one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic refwin_pkg::out_row_t expected_pel(input refwin_pkg::row_addr_t y,
                                                          input refwin_pkg::pel_ofs_t x);
        refwin_pkg::out_row_t  res;
        refwin_pkg::bank_row_t br;
        int win_bank [3];
        int row;
        int xc;
        int step;
        int p;
        win_bank[0] = (rot_m + 2) % 4;    // Leftmost
        win_bank[1] = (rot_m + 3) % 4;
        win_bank[2] = rot_m;
        row  = (y < pic_rows_m) ? y : pic_rows_m - 1;
        xc   = (x > 16) ? 16 : x;
        step = (mode_m == refwin_pkg::MODE_DOWNSAMPLE) ? 2 : 1;
        for (int j = 0; j < 4; j++) begin
            p  = xc + j * step;
            br = mem_m[win_bank[p / 8]][row];
            res[(3 - j) * PW +: PW] = br[(7 - p % 8) * PW +: PW];
        end
        return res;
    endfunction

    function automatic refwin_pkg::reg_data_t expected_reg(input refwin_pkg::reg_addr_e adr);
        if (adr == refwin_pkg::REG_MODE) begin
            return refwin_pkg::reg_data_t'(mode_m);
        end
        return refwin_pkg::reg_data_t'(pic_rows_m);
    endfunction

    // ****************************************
    // Bus and stimulus tasks
    // ****************************************
    task automatic wb_access(input refwin_pkg::reg_addr_e adr, input logic we,
                             input refwin_pkg::reg_data_t wdat,
                             output refwin_pkg::reg_data_t rdat);
        int waited;
        waited = 0;
        @(posedge clk);
        wb_cyc_i <= 1'b1;
        wb_stb_i <= 1'b1;
        wb_we_i  <= we;
        wb_adr_i <= adr;
        wb_dat_i <= wdat;
        do begin
            @(negedge clk);
            waited++;
        end while (!wb_ack_o && waited < 8);
        if (!wb_ack_o) begin
            stop_with_error("No Wishbone ack within 8 cycles");
        end
        rdat = wb_dat_o;
        @(posedge clk);
        wb_cyc_i <= 1'b0;
        wb_stb_i <= 1'b0;
        wb_we_i  <= 1'b0;
        @(negedge clk);
        if (wb_ack_o) begin
            stop_with_error("Wishbone ack stayed high for more than one cycle");
        end
    endtask

    task automatic reg_write(input refwin_pkg::reg_addr_e adr, input refwin_pkg::reg_data_t d);
        refwin_pkg::reg_data_t unused;
        wb_access(adr, 1'b1, d, unused);
        if (adr == refwin_pkg::REG_MODE) begin
            mode_m = refwin_pkg::fetch_mode_e'(d[0]);
        end else begin
            pic_rows_m = (d == 0) ? 1 : ((d > DEPTH) ? DEPTH : d);   // Saturated
        end
    endtask

    task automatic reg_read_check(input refwin_pkg::reg_addr_e adr);
        refwin_pkg::reg_data_t rd;
        wb_access(adr, 1'b0, '0, rd);
        check_reg("wb_dat_o", rd, expected_reg(adr));
    endtask

    task automatic start_pulse();
        @(posedge clk);
        start_i <= 1'b1;
        rot_m = (rot_m + 1) % 4;
        @(posedge clk);
        start_i <= 1'b0;
    endtask

    // Fill every row of the current load bank
    task automatic load_rows();
        logic [31:0] hi;
        logic [31:0] lo;
        for (int r = 0; r < DEPTH; r++) begin
            hi = take_bits(32);
            lo = take_bits(32);
            @(posedge clk);
            load_valid_i <= 1'b1;
            load_addr_i  <= refwin_pkg::row_addr_t'(r);
            load_data_i  <= {hi, lo};
            mem_m[(rot_m + 1) % 4][r] = {hi, lo};
        end
        @(posedge clk);
        load_valid_i <= 1'b0;
    endtask

    task automatic fill_banks();
        load_rows();
        repeat (3) begin
            start_pulse();
            load_rows();
        end
    endtask

    // Result due three counter steps from here
    task automatic fetch_one(input refwin_pkg::row_addr_t y, input refwin_pkg::pel_ofs_t x);
        @(posedge clk);
        fetch_en_i <= 1'b1;
        fetch_x_i  <= x;
        fetch_y_i  <= y;
        exp_pel_q.push_back(expected_pel(y, x));
        exp_due_q.push_back(cycle + 3);
    endtask

    task automatic finish_fetches();
        @(posedge clk);
        fetch_en_i <= 1'b0;
        while (exp_pel_q.size() != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic run_random_fetches(input int n);
        refwin_pkg::row_addr_t y;
        refwin_pkg::pel_ofs_t  x;
        for (int i = 0; i < n; i++) begin
            y = refwin_pkg::row_addr_t'(take_bits(4));
            x = refwin_pkg::pel_ofs_t'(take_bits(5));
            fetch_one(y, x);
        end
        finish_fetches();
    endtask

    // Every row at the left, middle and right bank
    task automatic scan_window();
        for (int y = 0; y < DEPTH; y++) begin
            for (int b = 0; b < 3; b++) begin
                fetch_one(refwin_pkg::row_addr_t'(y), refwin_pkg::pel_ofs_t'(b * 8));
            end
        end
        finish_fetches();
    endtask

    // ****************************************
    // Compare process and timeout
    // ****************************************
    always @(negedge clk) begin
        if (rstn && pel_valid_o) begin
            if (exp_pel_q.size() == 0) begin
                stop_with_error("Fetch result appeared with no fetch outstanding");
            end else if (exp_due_q[0] != cycle) begin
                stop_with_error($sformatf("Fetch result on cycle %0d, expected on cycle %0d",
                                          cycle, exp_due_q[0]));
            end else begin
                check_pel("pel_o", pel_o, exp_pel_q.pop_front());
                void'(exp_due_q.pop_front());
            end
        end else if (exp_due_q.size() != 0 && exp_due_q[0] < cycle) begin
            stop_with_error("Expected fetch result never appeared");
        end
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) begin
            stop_with_error($sformatf("Timeout reached after %0d cycles", cycle));
        end
    end

    // ****************************************
    // Test sequence
    // ****************************************
    initial begin
        rstn         = 1'b0;
        wb_cyc_i     = 1'b0;
        wb_stb_i     = 1'b0;
        wb_we_i      = 1'b0;
        wb_adr_i     = refwin_pkg::REG_PIC_ROWS;
        wb_dat_i     = '0;
        load_valid_i = 1'b0;
        load_addr_i  = '0;
        load_data_i  = '0;
        start_i      = 1'b0;
        fetch_en_i   = 1'b0;
        fetch_x_i    = '0;
        fetch_y_i    = '0;

        repeat (16) @(posedge clk);
        rstn <= 1'b1;
        @(negedge clk);
        if (pel_valid_o !== 1'b0 || wb_ack_o !== 1'b0) begin
            stop_with_error("pel_valid_o or wb_ack_o high after reset");
        end
        check_pel("pel_o", pel_o, '0);
        reg_read_check(refwin_pkg::REG_PIC_ROWS);
        reg_read_check(refwin_pkg::REG_MODE);

        // Register readback and saturation
        reg_write(refwin_pkg::REG_PIC_ROWS, 8'd9);
        reg_read_check(refwin_pkg::REG_PIC_ROWS);
        reg_write(refwin_pkg::REG_PIC_ROWS, 8'd0);
        reg_read_check(refwin_pkg::REG_PIC_ROWS);
        reg_write(refwin_pkg::REG_PIC_ROWS, 8'd200);
        reg_read_check(refwin_pkg::REG_PIC_ROWS);
        reg_write(refwin_pkg::REG_MODE, 8'd1);
        reg_read_check(refwin_pkg::REG_MODE);
        reg_write(refwin_pkg::REG_MODE, 8'd0);
        reg_read_check(refwin_pkg::REG_MODE);

        repeat (2) begin
            fill_banks();
            run_random_fetches(NUM_FETCH);
        end

        // Downsample, offsets past 16 included
        reg_write(refwin_pkg::REG_MODE, 8'd1);
        run_random_fetches(NUM_FETCH / 2);
        fetch_one(4'd3, 5'd16);
        fetch_one(4'd7, 5'd20);
        fetch_one(4'd12, 5'd31);
        finish_fetches();
        reg_write(refwin_pkg::REG_MODE, 8'd0);

        // Row clamp below full height
        reg_write(refwin_pkg::REG_PIC_ROWS, 8'd10);
        reg_read_check(refwin_pkg::REG_PIC_ROWS);
        run_random_fetches(NUM_FETCH / 2);
        fetch_one(4'd15, 5'd0);
        fetch_one(4'd10, 5'd4);
        finish_fetches();
        reg_write(refwin_pkg::REG_PIC_ROWS, 8'd16);

        // Full wrap, then reload one bank and bring it into the window
        repeat (4) start_pulse();
        scan_window();
        start_pulse();
        load_rows();
        start_pulse();
        scan_window();

        if (exp_pel_q.size() != 0) begin
            stop_with_error("Fetch results still outstanding at end of test");
        end else begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule
